// File: rtl/ws_timing_pkg.sv
package ws_timing_pkg;

    // cycle count inside one bit slot
    // 12 bits cover slots up to 4095 cycles of clk_100
    typedef logic [11:0] slot_count_t;

    // phase of the running bit slot, decoded from the slot counter
    // all fields stay low while the timer is stopped
    typedef struct packed {
        // first cycle of a slot
        logic slot_start;
        // last cycle of a slot
        logic slot_end;
        // counter still inside the zero-bit high time
        logic in_t0h;
        // counter still inside the one-bit high time
        logic in_t1h;
    } bit_phase_t;

    // the window for a one bit always covers the zero-bit window,
    // so a one bit is a zero bit with a longer high part

    // timer and encoder both read this struct
    // the shifter only looks at slot_start and slot_end

    // slot_start and slot_end never coincide
    // since a slot is always longer than one cycle

endpackage

// File: rtl/ws_pixel_pkg.sv
package ws_pixel_pkg;

    // colour as the host presents it
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // colour in the order the LEDs expect on the wire
    typedef struct packed {
        logic [7:0] g;
        logic [7:0] r;
        logic [7:0] b;
    } grb_t;

    // one pixel word, written per channel and sent as a bit string
    // bit 23 is the next bit on the line
    typedef union packed {
        grb_t        chan;
        logic [23:0] bits;
    } pixel_word_u;

    // host order to wire order
    function automatic grb_t to_grb(rgb_t c);
        grb_t w;
        w.g = c.g;
        w.r = c.r;
        w.b = c.b;
        return w;
    endfunction

endpackage

// File: rtl/ws_bit_timer.sv
`timescale 1ns/100ps

module ws_bit_timer #(
    parameter ws_timing_pkg::slot_count_t BIT_CYCLES = 12'd125,
    parameter ws_timing_pkg::slot_count_t T0H_CYCLES = 12'd35,
    parameter ws_timing_pkg::slot_count_t T1H_CYCLES = 12'd90
) (
    input  logic                      clk_100,
    input  logic                      arst_n,
    input  logic                      run,
    output ws_timing_pkg::bit_phase_t phase
);

    // last count value of a slot
    localparam ws_timing_pkg::slot_count_t LAST_CNT = BIT_CYCLES - 12'd1;

    ws_timing_pkg::slot_count_t cnt;

    // wraps 0 .. BIT_CYCLES-1 while running
    // parked at zero when stopped so the next run starts a fresh slot
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (!run || cnt == LAST_CNT) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 12'd1;
        end
    end

    // phase decode
    always_comb begin
        phase.slot_start = run && (cnt == '0);
        phase.slot_end   = run && (cnt == LAST_CNT);
        // high windows start at the slot start
        phase.in_t0h     = run && (cnt < T0H_CYCLES);
        phase.in_t1h     = run && (cnt < T1H_CYCLES);
    end

    // both high times must fit inside a slot, with a low tail after them
    a_timing_order: assert property (
        @(posedge clk_100)
        (T0H_CYCLES < T1H_CYCLES) && (T1H_CYCLES < BIT_CYCLES)
    ) else $error("bit timer: high times do not fit the slot");

endmodule

// File: rtl/ws_pixel_shifter.sv
`timescale 1ns/100ps

module ws_pixel_shifter #(
    parameter int BIT_CYCLES = 125,
    parameter int GAP_CYCLES = 5000
) (
    input  logic                      clk_100,
    input  logic                      arst_n,
    input  logic                      load,
    input  ws_pixel_pkg::rgb_t        pixel,
    input  logic                      blank,
    input  ws_timing_pkg::bit_phase_t phase,
    output logic                      run,
    output logic                      ready,
    output logic                      cur_bit,
    output logic                      active,
    output logic                      blank_cur,
    output logic                      frame_done
);

    // gap counter at least as wide as a slot count
    localparam int SLOT_W = $bits(ws_timing_pkg::slot_count_t);
    localparam int GAP_NEED = $clog2(GAP_CYCLES + 1);
    localparam int GAP_W = (GAP_NEED > SLOT_W) ? GAP_NEED : SLOT_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_GAP
    } state_t;

    state_t                    state;
    ws_pixel_pkg::rgb_t        next_px;
    logic                      next_valid;
    ws_pixel_pkg::pixel_word_u cur_word;
    logic [4:0]                bit_idx;
    logic [GAP_W-1:0]          gap_cnt;
    logic                      blank_q;
    logic                      last_bit_end;
    logic                      take_next;
    logic                      pix_start;

    // host side, one pixel can wait behind the one on the line
    assign ready = !next_valid;

    // timer runs exactly while a pixel is being sent
    assign run    = (state == ST_SEND);
    assign active = run;

    // msb of the word is on the line
    assign cur_bit = cur_word.bits[23];

    // end of bit 0, pixel finished
    assign last_bit_end = run && phase.slot_end && (bit_idx == 5'd0);
    // held pixel moves in from idle or straight after the last bit
    assign take_next = next_valid && ((state == ST_IDLE) || last_bit_end);

    // first slot of a pixel, blank is sampled here
    assign pix_start = phase.slot_start && (bit_idx == 5'd23);
    // sampled value already applies in the sampling cycle
    assign blank_cur = pix_start ? blank : blank_q;

    // next-pixel slot
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            next_valid <= 1'b0;
        end else if (load && ready) begin
            next_valid <= 1'b1;
        end else if (take_next) begin
            next_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_100) begin
        if (load && ready) begin
            next_px <= pixel;
        end
    end

    // current word, loaded per channel, shifted as bits
    always_ff @(posedge clk_100) begin
        if (take_next) begin
            cur_word.chan <= ws_pixel_pkg::to_grb(next_px);
        end else if (run && phase.slot_end) begin
            cur_word.bits <= {cur_word.bits[22:0], 1'b0};
        end
    end

    // FSM, bit index and latch gap
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            bit_idx    <= 5'd0;
            gap_cnt    <= '0;
            blank_q    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (pix_start) begin
                blank_q <= blank;
            end
            case (state)
                ST_IDLE: begin
                    if (take_next) begin
                        state   <= ST_SEND;
                        bit_idx <= 5'd23;
                    end
                end
                ST_SEND: begin
                    if (phase.slot_end) begin
                        if (bit_idx != 5'd0) begin
                            bit_idx <= bit_idx - 5'd1;
                        end else if (take_next) begin
                            // back to back, no pause on the line
                            bit_idx <= 5'd23;
                        end else begin
                            state   <= ST_GAP;
                            gap_cnt <= '0;
                        end
                    end
                end
                ST_GAP: begin
                    // line held low, LEDs latch
                    if (gap_cnt == GAP_W'(GAP_CYCLES - 1)) begin
                        state      <= ST_IDLE;
                        frame_done <= 1'b1;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // latch gap must outlast a bit slot
    a_gap_len: assert property (
        @(posedge clk_100) GAP_CYCLES > BIT_CYCLES
    ) else $error("pixel shifter: latch gap shorter than a slot");

    // timer is quiet while nothing is being sent
    a_idle_quiet: assert property (
        @(posedge clk_100) disable iff (!arst_n)
        (state == ST_IDLE && !next_valid) |-> !phase.slot_end
    ) else $error("pixel shifter: slot end while idle");

    // held pixel is never overwritten, host must wait for ready
    a_no_overwrite: assert property (
        @(posedge clk_100) disable iff (!arst_n)
        load |-> !next_valid
    ) else $error("pixel shifter: load while a pixel is held");

endmodule

// File: rtl/ws_line_encoder.sv
`timescale 1ns/100ps

module ws_line_encoder (
    input  logic                      clk_100,
    input  logic                      arst_n,
    input  ws_timing_pkg::bit_phase_t phase,
    input  logic                      cur_bit,
    input  logic                      active,
    input  logic                      blank_cur,
    output logic                      dout
);

    logic win;
    logic line_nxt;

    // long window for a one, short window for a zero
    always_comb begin
        if (cur_bit) begin
            win = phase.in_t1h;
        end else begin
            win = phase.in_t0h;
        end
    end

    // nothing on the line outside a pixel or for a blanked pixel
    assign line_nxt = win && active && !blank_cur;

    // output flop, no glitches from the decode reach the pin
    // one cycle behind the phase
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            dout <= 1'b0;
        end else begin
            dout <= line_nxt;
        end
    end

    // line stays low one cycle after the shifter stops sending
    a_low_when_idle: assert property (
        @(posedge clk_100) disable iff (!arst_n)
        !$past(active) |-> !dout
    ) else $error("line encoder: dout high without an active pixel");

endmodule

// File: rtl/ws2812_tx.sv
`timescale 1ns/100ps

module ws2812_tx #(
    // clk_100 cycles, 1.25 us slot
    parameter ws_timing_pkg::slot_count_t BIT_CYCLES = 12'd125,
    // 0.35 us high for a zero
    parameter ws_timing_pkg::slot_count_t T0H_CYCLES = 12'd35,
    // 0.9 us high for a one
    parameter ws_timing_pkg::slot_count_t T1H_CYCLES = 12'd90,
    // 50 us latch
    parameter int                         GAP_CYCLES = 5000
) (
    input  logic               clk_100,
    input  logic               arst_n,
    input  logic               load,
    input  ws_pixel_pkg::rgb_t pixel,
    input  logic               blank,
    output logic               ready,
    output logic               dout,
    output logic               frame_done
);

    ws_timing_pkg::bit_phase_t phase;
    logic                      run;
    logic                      cur_bit;
    logic                      active;
    logic                      blank_cur;

    // slot timing
    ws_bit_timer #(
        .BIT_CYCLES (BIT_CYCLES),
        .T0H_CYCLES (T0H_CYCLES),
        .T1H_CYCLES (T1H_CYCLES)
    ) ws_bit_timer_i (
        .clk_100 (clk_100),
        .arst_n  (arst_n),
        .run     (run),
        .phase   (phase)
    );

    // pixel buffer, bit order and latch gap
    ws_pixel_shifter #(
        .BIT_CYCLES (int'(BIT_CYCLES)),
        .GAP_CYCLES (GAP_CYCLES)
    ) ws_pixel_shifter_i (
        .clk_100    (clk_100),
        .arst_n     (arst_n),
        .load       (load),
        .pixel      (pixel),
        .blank      (blank),
        .phase      (phase),
        .run        (run),
        .ready      (ready),
        .cur_bit    (cur_bit),
        .active     (active),
        .blank_cur  (blank_cur),
        .frame_done (frame_done)
    );

    // serial line
    ws_line_encoder ws_line_encoder_i (
        .clk_100   (clk_100),
        .arst_n    (arst_n),
        .phase     (phase),
        .cur_bit   (cur_bit),
        .active    (active),
        .blank_cur (blank_cur),
        .dout      (dout)
    );

endmodule

// File: tb/ws2812_tx_tb.sv
`timescale 1ns/100ps

module ws2812_tx_tb;

    // slot timing on the wire
    localparam int BIT_CYCLES  = 125;
    localparam int T0H_CYCLES  = 35;
    localparam int T1H_CYCLES  = 90;
    // short latch gap to keep the run short
    localparam int GAP_CYCLES  = 400;
    localparam int NUM_ENTRIES = 10;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * (24 * BIT_CYCLES + GAP_CYCLES) + 1000;

    // one stimulus row
    typedef struct packed {
        ws_pixel_pkg::rgb_t pixel;
        logic               blank;
        logic               back_to_back;
    } stim_t;

    logic               clk_100 = 1'b0;
    logic               arst_n;
    logic               load;
    ws_pixel_pkg::rgb_t pixel;
    logic               blank;
    logic               ready;
    logic               dout;
    logic               frame_done;

    stim_t tbl [NUM_ENTRIES];
    string names [NUM_ENTRIES];

    // expected pixels in wire order without blanked rows
    ws_pixel_pkg::grb_t exp_q[$];
    string              exp_name_q[$];

    // serial decoder state
    logic        dout_q = 1'b0;
    logic        seen_rise = 1'b0;
    logic [23:0] shift_reg = '0;
    int          hi_len = 0;
    int          low_len = 0;
    int          since_rise = 0;
    int          bit_cnt = 0;
    int          pix_cnt = 0;
    int          frame_cnt = 0;
    int          cycles = 0;

    ws2812_tx #(
        .GAP_CYCLES (GAP_CYCLES)
    ) ws2812_tx_i (
        .clk_100    (clk_100),
        .arst_n     (arst_n),
        .load       (load),
        .pixel      (pixel),
        .blank      (blank),
        .ready      (ready),
        .dout       (dout),
        .frame_done (frame_done)
    );

    always #5 clk_100 = ~clk_100;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_pixel(input string name, input ws_pixel_pkg::grb_t exp,
                               input ws_pixel_pkg::grb_t act);
        if (act !== exp) begin
            stop_run($sformatf("error %s: expected g=%h r=%h b=%h, actual g=%h r=%h b=%h",
                               name, exp.g, exp.r, exp.b, act.g, act.r, act.b));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic set_entry(input int idx, input logic [23:0] rgb, input logic blk,
                             input logic b2b, input string name);
        tbl[idx]   = {rgb, blk, b2b};
        names[idx] = name;
    endtask

    // one finished high pulse
    // 24 of them make a pixel
    task automatic decode_bit(input int width);
        logic               b;
        ws_pixel_pkg::grb_t got;
        if (width == T1H_CYCLES) begin
            b = 1'b1;
        end else if (width == T0H_CYCLES) begin
            b = 1'b0;
        end else begin
            b = 1'b0;
            stop_run($sformatf("high pulse of %0d cycles is neither a zero nor a one", width));
        end
        // msb first on the wire
        shift_reg = {shift_reg[22:0], b};
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == 24) begin
            bit_cnt = 0;
            pix_cnt = pix_cnt + 1;
            got = shift_reg;
            if (exp_q.size() == 0) begin
                stop_run("a pixel came out of the line with none expected");
            end else begin
                check_pixel(exp_name_q.pop_front(), exp_q.pop_front(), got);
            end
        end
    endtask

    // line monitor sampled away from the rising edge
    always @(negedge clk_100) begin
        if (arst_n) begin
            since_rise = since_rise + 1;
            if (dout && !dout_q) begin
                // rises sit one slot apart inside a pixel or back to back
                if (seen_rise && (bit_cnt != 0 || since_rise <= GAP_CYCLES)) begin
                    check_count("rise to rise", BIT_CYCLES, since_rise);
                end
                seen_rise  = 1'b1;
                since_rise = 0;
                hi_len     = 0;
            end
            if (dout) begin
                hi_len  = hi_len + 1;
                low_len = 0;
            end else begin
                low_len = low_len + 1;
            end
            if (!dout && dout_q) begin
                decode_bit(hi_len);
            end
            if (frame_done) begin
                frame_cnt = frame_cnt + 1;
                if (low_len < GAP_CYCLES) begin
                    stop_run("frame_done came before the line was low for a full latch gap");
                end
            end
            dout_q = dout;
        end
    end

    // run limit
    always @(posedge clk_100) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_run($sformatf("timeout, no end of test after %0d cycles", cycles));
        end
    end

    // ends on a falling edge
    task automatic wait_frames(input int n);
        while (frame_cnt < n) begin
            @(posedge clk_100);
        end
        @(negedge clk_100);
    endtask

    task automatic load_entry(input int idx);
        load  = 1'b1;
        pixel = tbl[idx].pixel;
        blank = tbl[idx].blank;
        @(negedge clk_100);
        load = 1'b0;
        check_level({names[idx], " ready low"}, 1'b0, ready);
        // hold blank until the pixel moves in and samples it
        while (!ready) begin
            @(negedge clk_100);
        end
        @(negedge clk_100);
    endtask

    initial begin
        ws_pixel_pkg::grb_t want;
        logic [31:0]        rnd;
        int                 runs;
        int                 exp_frames;
        int                 exp_pixels;
        arst_n = 1'b0;
        load   = 1'b0;
        pixel  = '0;
        blank  = 1'b0;

        // fixed rows then random colours
        set_entry(0, 24'hff0000, 1'b0, 1'b0, "single red");
        set_entry(1, 24'ha53c0f, 1'b0, 1'b0, "single mixed");
        set_entry(2, 24'h0180fe, 1'b0, 1'b0, "run first");
        set_entry(3, 24'h55aac3, 1'b0, 1'b1, "back to back");
        set_entry(4, 24'hffffff, 1'b1, 1'b1, "blanked");
        set_entry(5, 24'h000180, 1'b0, 1'b1, "after blank");
        rnd = 32'h1413168f;
        for (int i = 6; i < NUM_ENTRIES; i++) begin
            rnd = xorshift32(rnd);
            set_entry(i, rnd[23:0], 1'b0, logic'(i % 2), $sformatf("random %0d", i));
        end

        // one frame per run and one pixel per unblanked row
        exp_frames = 0;
        exp_pixels = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!tbl[i].back_to_back) begin
                exp_frames = exp_frames + 1;
            end
            if (!tbl[i].blank) begin
                exp_pixels = exp_pixels + 1;
            end
        end

        repeat (16) @(posedge clk_100);
        @(negedge clk_100);
        arst_n = 1'b1;

        // quiet line before the first load
        repeat (8) begin
            @(negedge clk_100);
            check_level("idle ready", 1'b1, ready);
            check_level("idle dout", 1'b0, dout);
            check_level("idle frame_done", 1'b0, frame_done);
        end

        runs = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // a new run starts after the previous frame_done
            if (!tbl[i].back_to_back) begin
                wait_frames(runs);
                runs = runs + 1;
            end
            while (!ready) begin
                @(negedge clk_100);
            end
            if (!tbl[i].blank) begin
                want.g = tbl[i].pixel.g;
                want.r = tbl[i].pixel.r;
                want.b = tbl[i].pixel.b;
                exp_q.push_back(want);
                exp_name_q.push_back(names[i]);
            end
            load_entry(i);
        end

        wait_frames(runs);
        repeat (20) @(negedge clk_100);
        check_count("frame_done count", exp_frames, frame_cnt);
        check_count("pixel count", exp_pixels, pix_cnt);

        $display("all tests passed");
        $finish;
    end

endmodule

// File: vlog.f
rtl/ws_timing_pkg.sv
rtl/ws_pixel_pkg.sv
rtl/ws_bit_timer.sv
rtl/ws_pixel_shifter.sv
rtl/ws_line_encoder.sv
rtl/ws2812_tx.sv
tb/ws2812_tx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= ws2812_tx_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
